//--- Makefile
# Verilator flow for the CGRA column: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= tb_cgra_col
RTL_TOP   ?= cgra_col
FILELIST  ?= cgra_col.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
RTL_SRCS  ?= src/cgra_col_pkg.sv src/col_mem_arbiter.sv src/col_rvalid_router.sv \
             src/col_result_regs.sv src/cgra_col.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- cgra_col.f
src/cgra_col_pkg.sv
src/col_mem_arbiter.sv
src/col_rvalid_router.sv
src/col_result_regs.sv
src/cgra_col.sv
verif/tb_clkgen.sv
verif/tb_cgra_col.sv

//--- src/cgra_col.sv
//--------------------------------------------------------------------
// One CGRA column: memory arbitration, read routing, result registers.
// Cell requests, results and nop bits come in as top-level inputs.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module cgra_col #(
  parameter int unsigned N_ROW = cgra_col_pkg::N_ROW_DEF
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   pc_en_i,
  input  cgra_col_pkg::rc_mem_req_t [N_ROW-1:0]  rc_req_i,
  input  logic [N_ROW-1:0]                       rc_nop_i,
  input  cgra_col_pkg::data_t [N_ROW-1:0]        alu_res_i,
  input  cgra_col_pkg::alu_flag_t [N_ROW-1:0]    alu_flag_i,
  output cgra_col_pkg::mem_port_t                mem_port_o,
  input  logic                                   mem_gnt_i,
  input  logic                                   mem_rvalid_i,
  input  cgra_col_pkg::data_t                    mem_rdata_i,
  output cgra_col_pkg::data_t [N_ROW-1:0]        res_o,
  output cgra_col_pkg::alu_flag_t [N_ROW-1:0]    flag_o
);

  // Cell accepted this cycle and cell receiving read data
  logic [N_ROW-1:0] gnt_sel;
  logic [N_ROW-1:0] rvalid_sel;

  col_mem_arbiter #(.N_ROW(N_ROW)) u_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .pc_en_i    (pc_en_i),
    .rc_req_i   (rc_req_i),
    .mem_gnt_i  (mem_gnt_i),
    .mem_port_o (mem_port_o),
    .gnt_sel_o  (gnt_sel)
  );

  col_rvalid_router #(.N_ROW(N_ROW)) u_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .pc_en_i      (pc_en_i),
    .rc_req_i     (rc_req_i),
    .mem_rvalid_i (mem_rvalid_i),
    .rvalid_sel_o (rvalid_sel)
  );

  col_result_regs #(.N_ROW(N_ROW)) u_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .pc_en_i      (pc_en_i),
    .rc_req_i     (rc_req_i),
    .rc_nop_i     (rc_nop_i),
    .alu_res_i    (alu_res_i),
    .alu_flag_i   (alu_flag_i),
    .rvalid_sel_i (rvalid_sel),
    .mem_rdata_i  (mem_rdata_i),
    .res_o        (res_o),
    .flag_o       (flag_o)
  );

endmodule

//--- src/cgra_col_pkg.sv
//--------------------------------------------------------------------
// Shared widths, row count and packed types for one CGRA column.
// Compiled first; modules import it or use scoped names in headers.
//--------------------------------------------------------------------

package cgra_col_pkg;

  // Datapath word width
  parameter int unsigned DP_WIDTH = 32;

  // Default number of cells stacked in a column
  parameter int unsigned N_ROW_DEF = 4;

  // ALU flag count, matches alu_flag_t below
  parameter int unsigned N_FLAG = 2;

  typedef logic [DP_WIDTH-1:0] data_t;

  // Sign bit is the upper flag, zero test the lower one
  typedef struct packed {
    logic neg;
    logic zero;
  } alu_flag_t;

  // Memory request as issued by one cell
  typedef struct packed {
    logic  req;
    logic  wen;    // 1 means read
    data_t add;
    data_t wdata;
  } rc_mem_req_t;

  // Shared data-memory port leaving the column
  typedef struct packed {
    logic  req;
    logic  wen;    // 1 means read
    data_t add;
    data_t wdata;
  } mem_port_t;

endpackage

//--- src/col_mem_arbiter.sv
//--------------------------------------------------------------------
// Fixed-priority arbiter for the column's shared memory port.
// A grant mask serves each requesting cell once per instruction step.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module col_mem_arbiter #(
  parameter int unsigned N_ROW = cgra_col_pkg::N_ROW_DEF
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   pc_en_i,
  input  cgra_col_pkg::rc_mem_req_t [N_ROW-1:0]  rc_req_i,
  input  logic                                   mem_gnt_i,
  output cgra_col_pkg::mem_port_t                mem_port_o,
  output logic [N_ROW-1:0]                       gnt_sel_o
);

  import cgra_col_pkg::*;

  logic [N_ROW-1:0] gnt_mask_q;
  logic [N_ROW-1:0] req_masked;
  logic [N_ROW-1:0] pick;
  mem_port_t        port_d;

  // Requests that still wait for service in this step
  always_comb begin
    for (int i = 0; i < N_ROW; i++) begin
      req_masked[i] = rc_req_i[i].req & gnt_mask_q[i];
    end
  end

  // Isolate the lowest set bit
  assign pick = req_masked & (~req_masked + 1'b1);

  //------------------------------------------------------------------
  // Port mux
  //------------------------------------------------------------------

  always_comb begin
    port_d = '0;
    for (int i = 0; i < N_ROW; i++) begin
      if (pick[i]) begin
        port_d.req   = 1'b1;
        port_d.wen   = rc_req_i[i].wen;
        port_d.add   = rc_req_i[i].add;
        port_d.wdata = rc_req_i[i].wdata;
      end
    end
  end

  assign mem_port_o = port_d;

  // Accepted cell, only while the memory grants
  assign gnt_sel_o = pick & {N_ROW{mem_gnt_i}};

  //------------------------------------------------------------------
  // Grant mask
  //------------------------------------------------------------------

  // Re-armed at each step, a bit drops once its cell is accepted
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_mask_q <= '1;
    end else if (pc_en_i) begin
      gnt_mask_q <= '1;
    end else begin
      gnt_mask_q <= gnt_mask_q & ~gnt_sel_o;
    end
  end

  // At most one cell is accepted per cycle
  a_gnt_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(gnt_sel_o)
  );

  // The memory only grants a pending request
  a_gnt_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(mem_gnt_i) |-> mem_port_o.req
  );

endmodule

//--- src/col_result_regs.sv
//--------------------------------------------------------------------
// Per-cell result and flag registers, loaded at each step strobe.
// Read words arriving before the step wait in a temporary buffer.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module col_result_regs #(
  parameter int unsigned N_ROW = cgra_col_pkg::N_ROW_DEF
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   pc_en_i,
  input  cgra_col_pkg::rc_mem_req_t [N_ROW-1:0]  rc_req_i,
  input  logic [N_ROW-1:0]                       rc_nop_i,
  input  cgra_col_pkg::data_t [N_ROW-1:0]        alu_res_i,
  input  cgra_col_pkg::alu_flag_t [N_ROW-1:0]    alu_flag_i,
  input  logic [N_ROW-1:0]                       rvalid_sel_i,
  input  cgra_col_pkg::data_t                    mem_rdata_i,
  output cgra_col_pkg::data_t [N_ROW-1:0]        res_o,
  output cgra_col_pkg::alu_flag_t [N_ROW-1:0]    flag_o
);

  import cgra_col_pkg::*;

  data_t     [N_ROW-1:0] tmp_res_q;
  alu_flag_t [N_ROW-1:0] tmp_flag_q;
  alu_flag_t             rd_flag;

  // Flags of a loaded word: sign bit and all-zero test
  function automatic alu_flag_t word_flags(input data_t w);
    logic [N_FLAG-1:0] f;
    f = {w[DP_WIDTH-1], ~(|w)};
    return alu_flag_t'(f);
  endfunction

  assign rd_flag = word_flags(mem_rdata_i);

  //------------------------------------------------------------------
  // Early read data
  //------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N_ROW; i++) begin
      if (!pc_en_i && rvalid_sel_i[i]) begin
        tmp_res_q[i]  <= mem_rdata_i;
        tmp_flag_q[i] <= rd_flag;
      end
    end
  end

  //------------------------------------------------------------------
  // Step registers
  //------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_o  <= '0;
      flag_o <= '0;
    end else if (pc_en_i) begin
      for (int i = 0; i < N_ROW; i++) begin
        // Nop cells keep their value
        if (!rc_nop_i[i]) begin
          if (!rc_req_i[i].req) begin
            res_o[i]  <= alu_res_i[i];
            flag_o[i] <= alu_flag_i[i];
          end else if (rvalid_sel_i[i]) begin
            res_o[i]  <= mem_rdata_i;
            flag_o[i] <= rd_flag;
          end else begin
            res_o[i]  <= tmp_res_q[i];
            flag_o[i] <= tmp_flag_q[i];
          end
        end
      end
    end
  end

  // Router hands each read word to a single cell
  a_rvalid_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(rvalid_sel_i)
  );

endmodule

//--- src/col_rvalid_router.sv
//--------------------------------------------------------------------
// Routes each returning read valid to the oldest cell still waiting.
// Reads return in grant order, so the lowest pending index wins.
//--------------------------------------------------------------------
`timescale 1ns/1ns

module col_rvalid_router #(
  parameter int unsigned N_ROW = cgra_col_pkg::N_ROW_DEF
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   pc_en_i,
  input  cgra_col_pkg::rc_mem_req_t [N_ROW-1:0]  rc_req_i,
  input  logic                                   mem_rvalid_i,
  output logic [N_ROW-1:0]                       rvalid_sel_o
);

  logic [N_ROW-1:0] rd_mask_q;
  logic [N_ROW-1:0] rd_cand;
  logic [N_ROW-1:0] rd_pick;

  // Read cells whose data has not come back yet
  always_comb begin
    for (int i = 0; i < N_ROW; i++) begin
      rd_cand[i] = rc_req_i[i].req & rc_req_i[i].wen & rd_mask_q[i];
    end
  end

  assign rd_pick      = rd_cand & (~rd_cand + 1'b1);
  assign rvalid_sel_o = rd_pick & {N_ROW{mem_rvalid_i}};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_mask_q <= '1;
    end else if (pc_en_i) begin
      rd_mask_q <= '1;
    end else begin
      rd_mask_q <= rd_mask_q & ~rvalid_sel_o;
    end
  end

  // No read data without an outstanding read
  a_rvalid_has_target: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) mem_rvalid_i |-> (|rd_cand)
  );

endmodule

//--- verif/cgra_col_vectors.txt
// Per cell 0..3: ctl(bit0 req, bit1 read, bit2 nop) add wdata alu_res alu_flag
// Then per cell 0..3: expected res and flag (bit1 neg, bit0 zero)
0 0 0 11 0 0 0 0 22 0 0 0 0 0 1 0 0 0 80000000 2 11 0 22 0 0 1 80000000 2
5 4 12345678 d 0 5 8 0 d 0 5 c ffffff80 d 0 5 10 7fffffff d 0 11 0 22 0 0 1 80000000 2
3 10 0 0 0 3 4 0 0 0 3 8 0 0 0 3 c 0 0 0 7fffffff 0 12345678 0 0 1 ffffff80 2
0 0 0 5 0 4 0 0 99 0 3 4 0 0 0 5 20 0 0 0 5 0 12345678 0 12345678 0 ffffff80 2
3 c 0 0 0 0 0 0 aaaa5555 2 0 0 0 1 0 3 20 0 0 0 ffffff80 2 aaaa5555 2 1 0 0 1
4 0 0 7 0 4 0 0 7 0 4 0 0 7 0 4 0 0 7 0 ffffff80 2 aaaa5555 2 1 0 0 1
5 30 55 0 0 3 30 0 0 0 3 10 0 0 0 0 0 0 3 0 ffffff80 2 55 0 7fffffff 0 3 0
0 0 0 0 1 0 0 0 2 0 0 0 0 3 0 0 0 0 4 0 0 1 2 0 3 0 4 0
3 8 0 0 0 3 8 0 0 0 3 8 0 0 0 3 8 0 0 0 0 1 0 1 0 1 0 1
3 30 0 0 0 7 4 0 0 0 5 8 9 0 0 3 8 0 0 0 55 0 0 1 0 1 9 0

//--- verif/tb_cgra_col.sv
//----------------------------------------------------------------------
// Column testbench: replays steps from the vectors file against a
// randomly granting memory model and checks results after each step
//----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_cgra_col;

  import cgra_col_pkg::*;

  localparam int unsigned N_ROW        = N_ROW_DEF;
  localparam int unsigned N_STEP       = 10;
  localparam int unsigned VEC_W        = 28;
  localparam int unsigned MEM_DEPTH    = 64;
  localparam int unsigned IDLE_TIMEOUT = 200;
  localparam int unsigned RST_TIMEOUT  = 20;

  logic                          clk_i;
  logic                          arst_n_i;
  logic                          pc_en_i;
  rc_mem_req_t [N_ROW-1:0]       rc_req_i;
  logic [N_ROW-1:0]              rc_nop_i;
  data_t [N_ROW-1:0]             alu_res_i;
  alu_flag_t [N_ROW-1:0]         alu_flag_i;
  mem_port_t                     mem_port_o;
  logic                          mem_gnt_i;
  logic                          mem_rvalid_i;
  data_t                         mem_rdata_i;
  data_t [N_ROW-1:0]             res_o;
  alu_flag_t [N_ROW-1:0]         flag_o;

  logic [31:0]     vec_mem [0:N_STEP*VEC_W-1];
  data_t           mem [0:MEM_DEPTH-1];
  int unsigned     rd_due[$];
  data_t           rd_data[$];
  int unsigned     cyc;
  int              seed = 32'h8ddf_d65e;
  logic [N_ROW-1:0] acc_mask;
  mem_port_t       prev_port;
  logic            prev_stall;

  tb_clkgen #(.PERIOD_NS(8), .RST_CYCLES(5)) u_clkgen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  cgra_col #(.N_ROW(N_ROW)) u_cgra_col (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .pc_en_i      (pc_en_i),
    .rc_req_i     (rc_req_i),
    .rc_nop_i     (rc_nop_i),
    .alu_res_i    (alu_res_i),
    .alu_flag_i   (alu_flag_i),
    .mem_port_o   (mem_port_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .res_o        (res_o),
    .flag_o       (flag_o)
  );

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  //--------------------------------------------------------------------
  // Memory model with random grants and in-order read returns
  //--------------------------------------------------------------------

  always @(posedge clk_i) begin : mem_model
    logic [31:0] rnd;
    int          exp_idx;
    int unsigned due;
    cyc = cyc + 1;
    if (arst_n_i) begin
      // Held port while the memory stalls
      if (prev_stall) begin
        assert (mem_port_o == prev_port) else
          fail_stop($sformatf("mismatch at %0t: port moved under stall, %h vs %h",
                              $time, mem_port_o, prev_port));
      end
      if (rd_due.size() > 0 && rd_due[0] == cyc) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= rd_data.pop_front();
        void'(rd_due.pop_front());
      end else begin
        mem_rvalid_i <= 1'b0;
      end
      if (mem_port_o.req && mem_gnt_i) begin
        exp_idx = -1;
        for (int i = 0; i < N_ROW; i++) begin
          if (exp_idx < 0 && rc_req_i[i].req && !acc_mask[i]) exp_idx = i;
        end
        assert (exp_idx >= 0) else
          fail_stop("memory accepted a request when no cell was left to serve");
        assert (mem_port_o.wen == rc_req_i[exp_idx].wen &&
                mem_port_o.add == rc_req_i[exp_idx].add &&
                mem_port_o.wdata == rc_req_i[exp_idx].wdata) else
          fail_stop($sformatf("mismatch at %0t: port %h, expected cell %0d",
                              $time, mem_port_o, exp_idx));
        acc_mask[exp_idx] = 1'b1;
        if (mem_port_o.wen) begin
          rnd = $random(seed);
          due = cyc + 1 + rnd[0];
          if (rd_due.size() > 0 && due <= rd_due[rd_due.size()-1]) begin
            due = rd_due[rd_due.size()-1] + 1;
          end
          rd_due.push_back(due);
          rd_data.push_back(mem[mem_port_o.add[7:2]]);
        end else begin
          mem[mem_port_o.add[7:2]] = mem_port_o.wdata;
        end
      end
      prev_stall = mem_port_o.req && !mem_gnt_i;
      prev_port  = mem_port_o;
      rnd = $random(seed);
      mem_gnt_i <= mem_port_o.req & rnd[0];
    end
  end

  // Idle port and no more than one read left, due on the next edge
  task automatic wait_step_ready(input int step);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!(!mem_port_o.req &&
             (rd_due.size() == 0 || (rd_due.size() == 1 && rd_due[0] == cyc + 1)))) begin
      n++;
      if (n > IDLE_TIMEOUT) fail_stop($sformatf("step %0d: memory port never went idle", step));
      @(negedge clk_i);
    end
  endtask

  //--------------------------------------------------------------------
  // Step sequence
  //--------------------------------------------------------------------

  initial begin
    int n;
    int unsigned base;
    logic [N_ROW-1:0] req_bits;
    pc_en_i      = 1'b0;
    rc_req_i     = '0;
    rc_nop_i     = '0;
    alu_res_i    = '0;
    alu_flag_i   = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    cyc          = 0;
    acc_mask     = '0;
    prev_stall   = 1'b0;
    prev_port    = '0;
    for (int i = 0; i < MEM_DEPTH; i++) mem[i] = 32'h5a00_0000 | (i << 8) | (i ^ 8'hff);
    $readmemh("verif/cgra_col_vectors.txt", vec_mem);

    n = 0;
    while (arst_n_i !== 1'b1) begin
      n++;
      if (n > RST_TIMEOUT) fail_stop("reset was never released");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    assert (mem_port_o == '0 && res_o == '0 && flag_o == '0) else
      fail_stop($sformatf("mismatch at %0t: state after reset not zero", $time));

    for (int s = 0; s < N_STEP; s++) begin
      @(posedge clk_i);
      for (int c = 0; c < N_ROW; c++) begin
        base = s * VEC_W + c * 5;
        rc_req_i[c].req   <= vec_mem[base][0];
        rc_req_i[c].wen   <= vec_mem[base][1];
        rc_nop_i[c]       <= vec_mem[base][2];
        rc_req_i[c].add   <= vec_mem[base+1];
        rc_req_i[c].wdata <= vec_mem[base+2];
        alu_res_i[c]      <= vec_mem[base+3];
        alu_flag_i[c]     <= vec_mem[base+4][1:0];
        req_bits[c]        = vec_mem[base][0];
      end
      acc_mask = '0;
      wait_step_ready(s);
      @(posedge clk_i);
      pc_en_i <= 1'b1;
      @(posedge clk_i);
      pc_en_i <= 1'b0;
      // Requests end with the step that issued them
      for (int c = 0; c < N_ROW; c++) begin
        rc_req_i[c].req <= 1'b0;
      end
      @(negedge clk_i);
      assert (acc_mask == req_bits && rd_due.size() == 0) else
        fail_stop($sformatf("mismatch at %0t: step %0d served %b, requests %b",
                            $time, s, acc_mask, req_bits));
      for (int c = 0; c < N_ROW; c++) begin
        base = s * VEC_W + 20 + c * 2;
        assert (res_o[c] == vec_mem[base] && flag_o[c] == vec_mem[base+1][1:0]) else
          fail_stop($sformatf("mismatch at %0t: step %0d cell %0d res %h/%b exp %h/%b",
                              $time, s, c, res_o[c], flag_o[c],
                              vec_mem[base], vec_mem[base+1][1:0]));
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verif/tb_clkgen.sv
//----------------------------------------------------------------------
// Testbench clock and reset source for the column testbench
//----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int unsigned PERIOD_NS  = 8,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
